// File: Makefile
VERILATOR  = verilator
FLIST      = flist.f
TOP        = adc_tb
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+1000
LOG        = sim.log
PASS_MSG   = all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+include
verilog/adc_pkg.sv
verilog/adc_apb_regs.sv
verilog/adc_modulator.sv
verilog/adc_ref_counters.sv
verilog/adc_top.sv
tb/adc_checker.sv
tb/adc_tb.sv

// File: include/adc_defs.svh
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// phase clock counts, reset / fix / var
`define ADC_COUNT_W 24
// aperture and signal count, long integrations
`define ADC_APER_W  32

// apb bus widths
`define APB_ADDR_W  8
`define APB_DATA_W  32

//////////////////////////////
// register map, byte offsets
`define REG_CTRL       8'h00
`define REG_RESET      8'h04
`define REG_FIX        8'h08
`define REG_VAR        8'h0c
`define REG_APER       8'h10
`define REG_STATUS     8'h14
`define REG_CNT_RESET  8'h18
`define REG_CNT_POS    8'h1c
`define REG_CNT_NEG    8'h20
`define REG_CNT_RD     8'h24
`define REG_CNT_SIG    8'h28

// ctrl register bits
`define CTRL_START_BIT 0
`define CTRL_SLOW_BIT  1

`endif

// File: tb/adc_checker.sv
`timescale 1ns/100ps
`default_nettype none

module adc_checker (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire adc_pkg::refmux_t  refmux,
  input  wire                    sigmux,
  input  wire                    cmpr_latch_disable,
  input  wire                    adc_valid,
  input  wire                    capture,
  input  wire                    slow_rundown
);

  // failure tally, read by the testbench summary
  int unsigned fails = 0;

  //////////////////////////////
  // switch combinations

  // signal switch stays open while the integrator is shorted
  sig_off_in_reset: assert property (@(posedge clk) disable iff (!arst_n)
    refmux == adc_pkg::refmux_reset |-> !sigmux)
  else
  begin
    fails++;
    $error("sigmux high while refmux holds the integrator in reset");
  end

  // slow reference only in slow rundown mode
  slow_only_when_set: assert property (@(posedge clk) disable iff (!arst_n)
    refmux == adc_pkg::refmux_slow_pos |-> slow_rundown)
  else
  begin
    fails++;
    $error("slow_pos reference used with slow rundown off");
  end

  // latch held closed whenever the integrator is in reset
  latch_off_in_reset: assert property (@(posedge clk) disable iff (!arst_n)
    refmux == adc_pkg::refmux_reset |-> cmpr_latch_disable)
  else
  begin
    fails++;
    $error("comparator latch enabled during integrator reset");
  end

  //////////////////////////////
  // end of measurement

  // valid follows the rundown comparator edge by one clock
  valid_after_capture: assert property (@(posedge clk) disable iff (!arst_n)
    capture |=> $rose(adc_valid))
  else
  begin
    fails++;
    $error("adc_valid did not rise one cycle after the rundown edge");
  end

  // and never rises without that edge
  valid_only_on_capture: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(adc_valid) |-> $past(capture))
  else
  begin
    fails++;
    $error("adc_valid rose without a rundown comparator edge");
  end

  // idle with result, everything parked
  valid_means_idle: assert property (@(posedge clk) disable iff (!arst_n)
    adc_valid |-> refmux == adc_pkg::refmux_reset && !sigmux)
  else
  begin
    fails++;
    $error("switches active while adc_valid is high");
  end

endmodule

`default_nettype wire

// File: tb/adc_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "adc_defs.svh"

module adc_tb;

  // integrator model weights per clock
  // neg a little stronger than pos so run-up drifts up and always finds its exit
  localparam int POS_W   = 1000;
  localparam int NEG_W   = 1100;
  localparam int SLOW_W  = 40;
  localparam int FIX_CNT = 4;
  localparam int VAR_CNT = 6;

  // six starts, aperture up to 305, run-up tail and slow rundown well below 2000
  localparam int N_MEAS      = 6;
  localparam int MAX_APER    = 305;
  localparam int CYCLE_LIMIT = N_MEAS * (MAX_APER + 2000) + 500;

  logic               clk = 1'b0;
  logic               arst_n = 1'b0;
  adc_pkg::apb_req_t  apb_req = '0;
  adc_pkg::apb_data_t prdata;
  logic               comparator_val = 1'b0;
  adc_pkg::refmux_t   refmux;
  logic               sigmux;
  logic               cmpr_latch_disable;
  logic               adc_valid;

  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned cycles = 0;
  // integrator charge in model units, signal weight of the running measurement
  int          integ = 0;
  int          sig_w = 0;
  logic [15:0] lfsr = 16'd42;

  adc_top adc_top_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .apb_req            (apb_req),
    .prdata             (prdata),
    .comparator_val     (comparator_val),
    .refmux             (refmux),
    .sigmux             (sigmux),
    .cmpr_latch_disable (cmpr_latch_disable),
    .adc_valid          (adc_valid)
  );

  bind adc_top adc_checker adc_checker_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .refmux             (refmux),
    .sigmux             (sigmux),
    .cmpr_latch_disable (cmpr_latch_disable),
    .adc_valid          (adc_valid),
    .capture            (capture),
    .slow_rundown       (params.slow_rundown)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  //////////////////////////////
  // integrator and comparator model
  // one step per clock for the switch setting of the cycle just begun
  always @(posedge clk)
  begin
    #5;
    case (refmux)
      adc_pkg::refmux_reset:    integ = 0;
      adc_pkg::refmux_pos:      integ = integ - POS_W;
      adc_pkg::refmux_neg:      integ = integ + NEG_W;
      adc_pkg::refmux_slow_pos: integ = integ - SLOW_W;
      default:                  ;
    endcase
    if (sigmux)
      integ = integ + sig_w;
    // high below the zero cross
    comparator_val = (integ < 0);
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("run stopped, no measurement finished within %0d cycles", CYCLE_LIMIT);
      errors++;
      finish_run();
    end
  end

  task automatic finish_run();
    int unsigned fails;
    fails = adc_top_i.adc_checker_i.fails;
    $display("%0d checks, %0d mismatches, %0d assertion failures", checks, errors, fails);
    if (errors + fails == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  task automatic check_eq(input string what, input int unsigned got, input int unsigned exp);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("Error at %0t: %s does not hold", $time, what);
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic int unsigned take_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return val;
  endfunction

  //////////////////////////////
  // apb host, setup then access cycle
  task automatic apb_write(input adc_pkg::apb_addr_t addr, input adc_pkg::apb_data_t data);
    @(posedge clk);
    #5;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    @(posedge clk);
    #5;
    apb_req = '0;
  endtask

  task automatic apb_read(input adc_pkg::apb_addr_t addr, output adc_pkg::apb_data_t data);
    @(posedge clk);
    #5;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    // mid access cycle, prdata settled
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    #5;
    apb_req = '0;
  endtask

  // valid must be gone once the start edge has passed
  task automatic start_measurement(input logic slow);
    apb_write(`REG_CTRL, {30'd0, slow, 1'b1});
    @(posedge clk);
    @(negedge clk);
    check_true("adc_valid low after start", !adc_valid);
  endtask

  task automatic wait_valid();
    while (!adc_valid)
      @(negedge clk);
  endtask

  task automatic check_results(input int unsigned aper, input int unsigned rst,
                               input logic slow);
    adc_pkg::apb_data_t st;
    adc_pkg::apb_data_t c_rst;
    adc_pkg::apb_data_t c_pos;
    adc_pkg::apb_data_t c_neg;
    adc_pkg::apb_data_t c_rd;
    adc_pkg::apb_data_t c_sig;
    int                 residual;
    int                 rd_w;
    apb_read(`REG_STATUS, st);
    check_eq("status valid bit", st & 32'd1, 32'd1);
    apb_read(`REG_CNT_SIG, c_sig);
    check_eq("signal count", c_sig, aper + 1);
    apb_read(`REG_CNT_RESET, c_rst);
    check_eq("reset count", c_rst, rst + 2);
    apb_read(`REG_CNT_POS, c_pos);
    apb_read(`REG_CNT_NEG, c_neg);
    apb_read(`REG_CNT_RD, c_rd);
    check_true("rd count matches rundown mode", slow ? (c_rd != 0) : (c_rd == 0));
    // charge left on the integrator at capture
    residual = sig_w * int'(c_sig) - POS_W * int'(c_pos) + NEG_W * int'(c_neg)
             - SLOW_W * int'(c_rd);
    rd_w = slow ? SLOW_W : POS_W;
    // crossing cycle plus the one rundown cycle counted before capture
    check_true("charge balance residual", residual < 0 && residual >= -2 * rd_w);
  endtask

  task automatic measure(input logic slow);
    int unsigned aper;
    int unsigned rst;
    int unsigned w;
    aper  = take_bits(8);
    rst   = take_bits(3);
    w     = take_bits(7);
    aper  = aper + 50;
    rst   = rst + 1;
    // stays below what two var phases remove per loop
    sig_w = int'(w) + 50;
    apb_write(`REG_RESET, rst);
    apb_write(`REG_APER, aper);
    start_measurement(slow);
    wait_valid();
    check_results(aper, rst, slow);
  endtask

  // second start lands in run-up, results belong to the new aperture
  task automatic restart_check();
    int unsigned aper;
    sig_w = 120;
    apb_write(`REG_RESET, 32'd2);
    apb_write(`REG_APER, 32'd300);
    start_measurement(1'b0);
    while (!sigmux)
      @(negedge clk);
    repeat (20)
      @(negedge clk);
    aper = take_bits(8);
    aper = aper + 50;
    apb_write(`REG_APER, aper);
    start_measurement(1'b0);
    wait_valid();
    check_results(aper, 2, 1'b0);
  endtask

  initial
  begin
    adc_pkg::apb_data_t rd;
    repeat (2)
      @(posedge clk);
    #5;
    arst_n = 1'b1;

    // reset defaults
    @(negedge clk);
    check_true("adc_valid low after reset", !adc_valid);
    check_true("sigmux low after reset", !sigmux);
    check_true("refmux reset after reset", refmux == adc_pkg::refmux_reset);
    check_true("comparator latch disabled after reset", cmpr_latch_disable);
    apb_read(`REG_APER, rd);
    check_eq("aperture after reset", rd, 0);
    apb_read(`REG_CNT_SIG, rd);
    check_eq("signal count after reset", rd, 0);

    // register readback
    apb_write(`REG_RESET, 32'd3);
    apb_write(`REG_FIX, FIX_CNT);
    apb_write(`REG_VAR, VAR_CNT);
    apb_write(`REG_APER, 32'd123);
    apb_write(`REG_CTRL, 32'h2);
    apb_read(`REG_RESET, rd);
    check_eq("reset register", rd, 3);
    apb_read(`REG_FIX, rd);
    check_eq("fix register", rd, FIX_CNT);
    apb_read(`REG_VAR, rd);
    check_eq("var register", rd, VAR_CNT);
    apb_read(`REG_APER, rd);
    check_eq("aperture register", rd, 123);
    apb_read(`REG_CTRL, rd);
    check_eq("ctrl register", rd, 2);
    apb_read(`REG_STATUS, rd);
    check_eq("status before first run", rd, 0);

    // slow and fast rundown in turn
    measure(1'b1);
    measure(1'b0);
    measure(1'b1);
    measure(1'b0);
    restart_check();
    finish_run();
  end

endmodule

`default_nettype wire

// File: verilog/adc_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "adc_defs.svh"

module adc_apb_regs (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire adc_pkg::apb_req_t      apb_req,
  output adc_pkg::apb_data_t          prdata,
  input  wire                         adc_valid,
  input  wire adc_pkg::adc_result_t   result,
  output adc_pkg::adc_params_t        params,
  output logic                        start
);

  // access cycle qualifiers, no wait states
  logic wr_en;
  logic rd_en;

  assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign rd_en = apb_req.psel && !apb_req.pwrite;

  // counts are narrower than the bus
  function automatic adc_pkg::apb_data_t ext_count(input adc_pkg::count_t c);
    ext_count = {{(`APB_DATA_W-`ADC_COUNT_W){1'b0}}, c};
  endfunction

  //////////////////////////////
  // write side
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      params <= '0;
      start  <= 1'b0;
    end
    else
    begin
      // start self clears after one cycle
      start <= 1'b0;

      if (wr_en)
      begin
        case (apb_req.paddr)
          `REG_CTRL:
          begin
            // start pulse shows the cycle after the access edge
            start               <= apb_req.pwdata[`CTRL_START_BIT];
            params.slow_rundown <= apb_req.pwdata[`CTRL_SLOW_BIT];
          end
          `REG_RESET:
            params.reset_cnt <= apb_req.pwdata[`ADC_COUNT_W-1:0];
          `REG_FIX:
            params.fix_cnt <= apb_req.pwdata[`ADC_COUNT_W-1:0];
          `REG_VAR:
            params.var_cnt <= apb_req.pwdata[`ADC_COUNT_W-1:0];
          `REG_APER:
            params.aperture <= apb_req.pwdata;
          // status and counts are read only
          default:
            ;
        endcase
      end
    end
  end

  //////////////////////////////
  // read side, data valid in the access cycle
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (apb_req.paddr)
        // start always reads back zero
        `REG_CTRL:      prdata[`CTRL_SLOW_BIT] = params.slow_rundown;
        `REG_RESET:     prdata = ext_count(params.reset_cnt);
        `REG_FIX:       prdata = ext_count(params.fix_cnt);
        `REG_VAR:       prdata = ext_count(params.var_cnt);
        `REG_APER:      prdata = params.aperture;
        `REG_STATUS:    prdata[0] = adc_valid;
        `REG_CNT_RESET: prdata = ext_count(result.reset_cnt);
        `REG_CNT_POS:   prdata = ext_count(result.pos_cnt);
        `REG_CNT_NEG:   prdata = ext_count(result.neg_cnt);
        `REG_CNT_RD:    prdata = ext_count(result.rd_cnt);
        `REG_CNT_SIG:   prdata = result.sig_cnt;
        default:        prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/adc_modulator.sv
`timescale 1ns/100ps
`default_nettype none

module adc_modulator (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire adc_pkg::adc_params_t   params,
  input  wire                         start,
  input  wire                         comparator_val,
  output adc_pkg::refmux_t            refmux,
  output logic                        sigmux,
  output logic                        cmpr_latch_disable,
  output logic                        capture,
  output logic                        adc_valid
);

  adc_pkg::mod_state_t state;
  adc_pkg::count_t     phase_cnt;
  adc_pkg::aper_t      aper_cnt;
  logic [2:0]          cmpr_sr;
  logic                cmpr_below;
  logic                cmpr_edge;

  // two flops deep, bit 2 only for edge detect
  assign cmpr_below = cmpr_sr[1];
  assign cmpr_edge  = cmpr_sr[2] ^ cmpr_sr[1];

  // first comparator edge in rundown ends the measurement
  // a restart in the same cycle wins
  assign capture = (state == adc_pkg::st_rundown) && cmpr_edge && !start;

  // below the cross, add neg ref to drive up
  function automatic adc_pkg::refmux_t var_dir(input logic below);
    var_dir = below ? adc_pkg::refmux_neg : adc_pkg::refmux_pos;
  endfunction

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state              <= adc_pkg::st_idle;
      phase_cnt          <= '0;
      aper_cnt           <= '0;
      cmpr_sr            <= '0;
      refmux             <= adc_pkg::refmux_reset;
      sigmux             <= 1'b0;
      cmpr_latch_disable <= 1'b1;
      adc_valid          <= 1'b0;
    end
    else
    begin
      cmpr_sr   <= {cmpr_sr[1:0], comparator_val};
      // free running, phases reload it
      phase_cnt <= phase_cnt - 1'b1;

      //////////////////////////////
      // aperture, independent of the run-up phases
      if (sigmux)
      begin
        aper_cnt <= aper_cnt + 1'b1;
        if (aper_cnt >= params.aperture)
          sigmux <= 1'b0;
      end

      case (state)
        // rest, integrator held in reset
        adc_pkg::st_idle:
          ;
        adc_pkg::st_reset:
          if (phase_cnt == '0)
            state <= adc_pkg::st_sig_start;
        adc_pkg::st_sig_start:
        begin
          state    <= adc_pkg::st_fix_pos_start;
          aper_cnt <= '0;
          sigmux   <= 1'b1;
          refmux   <= adc_pkg::refmux_none;
        end
        adc_pkg::st_fix_pos_start:
        begin
          state              <= adc_pkg::st_fix_pos;
          phase_cnt          <= params.fix_cnt;
          refmux             <= adc_pkg::refmux_pos;
          // comparator latch transparent
          cmpr_latch_disable <= 1'b0;
        end
        adc_pkg::st_fix_pos:
          if (phase_cnt == '0)
            state <= adc_pkg::st_var_start;
        adc_pkg::st_var_start:
        begin
          state     <= adc_pkg::st_var;
          phase_cnt <= params.var_cnt;
          refmux    <= var_dir(cmpr_below);
        end
        adc_pkg::st_var:
          if (phase_cnt == '0)
            state <= adc_pkg::st_fix_neg_start;
        adc_pkg::st_fix_neg_start:
        begin
          state     <= adc_pkg::st_fix_neg;
          phase_cnt <= params.fix_cnt;
          refmux    <= adc_pkg::refmux_neg;
        end
        adc_pkg::st_fix_neg:
          if (phase_cnt == '0)
            state <= adc_pkg::st_var2_start;
        adc_pkg::st_var2_start:
        begin
          state     <= adc_pkg::st_var2;
          phase_cnt <= params.var_cnt;
          refmux    <= var_dir(cmpr_below);
        end
        adc_pkg::st_var2:
          if (phase_cnt == '0)
          begin
            // exit once signal is off and an up phase left us above the cross
            if (!sigmux && refmux == adc_pkg::refmux_neg && !cmpr_below)
              state <= adc_pkg::st_prerundown;
            else
              state <= adc_pkg::st_fix_pos_start;
          end
        // neg ref kept one more cycle, margin above the cross
        adc_pkg::st_prerundown:
        begin
          state  <= adc_pkg::st_rundown;
          refmux <= params.slow_rundown ? adc_pkg::refmux_slow_pos : adc_pkg::refmux_pos;
        end
        adc_pkg::st_rundown:
          if (capture)
          begin
            state              <= adc_pkg::st_idle;
            refmux             <= adc_pkg::refmux_reset;
            sigmux             <= 1'b0;
            cmpr_latch_disable <= 1'b1;
            adc_valid          <= 1'b1;
          end
        default:
          state <= adc_pkg::st_idle;
      endcase

      // interruptible, start restarts from any state
      if (start)
      begin
        state              <= adc_pkg::st_reset;
        phase_cnt          <= params.reset_cnt;
        refmux             <= adc_pkg::refmux_reset;
        sigmux             <= 1'b0;
        cmpr_latch_disable <= 1'b1;
        adc_valid          <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/adc_pkg.sv
`default_nettype none

`include "adc_defs.svh"

package adc_pkg;

  // clock count for reset, fix and var phases
  typedef logic [`ADC_COUNT_W-1:0] count_t;
  // aperture and signal integration count
  typedef logic [`ADC_APER_W-1:0]  aper_t;
  typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
  typedef logic [`APB_DATA_W-1:0]  apb_data_t;

  // reference switch codes, two 4053 sections combined
  typedef enum logic [2:0] {
    refmux_none     = 3'b000,
    refmux_pos      = 3'b001,
    refmux_neg      = 3'b010,
    refmux_slow_pos = 3'b011,
    refmux_reset    = 3'b100
  } refmux_t;

  // modulator phases, each timed phase has a setup state in front
  typedef enum logic [3:0] {
    st_idle           = 4'd0,
    st_reset          = 4'd1,
    st_sig_start      = 4'd2,
    st_fix_pos_start  = 4'd3,
    st_fix_pos        = 4'd4,
    st_var_start      = 4'd5,
    st_var            = 4'd6,
    st_fix_neg_start  = 4'd7,
    st_fix_neg        = 4'd8,
    st_var2_start     = 4'd9,
    st_var2           = 4'd10,
    st_prerundown     = 4'd11,
    st_rundown        = 4'd12
  } mod_state_t;

  //////////////////////////////
  // host timing parameters
  typedef struct packed {
    count_t reset_cnt;
    count_t fix_cnt;
    count_t var_cnt;
    aper_t  aperture;
    logic   slow_rundown;
  } adc_params_t;

  // per reference clock counts of one measurement
  typedef struct packed {
    count_t reset_cnt;
    count_t pos_cnt;
    count_t neg_cnt;
    count_t rd_cnt;
    aper_t  sig_cnt;
  } adc_result_t;

  // host side of the apb bus
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

endpackage

`default_nettype wire

// File: verilog/adc_ref_counters.sv
`timescale 1ns/100ps
`default_nettype none

module adc_ref_counters (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         start,
  input  wire adc_pkg::refmux_t       refmux,
  input  wire                         sigmux,
  input  wire                         capture,
  output adc_pkg::adc_result_t        result
);

  // running counts, same layout as the captured result
  adc_pkg::adc_result_t run;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      run    <= '0;
      result <= '0;
    end
    else
    begin
      //////////////////////////////
      // one count per cycle for the active switch
      case (refmux)
        adc_pkg::refmux_reset:
          run.reset_cnt <= run.reset_cnt + 1'b1;
        adc_pkg::refmux_pos:
          run.pos_cnt <= run.pos_cnt + 1'b1;
        adc_pkg::refmux_neg:
          run.neg_cnt <= run.neg_cnt + 1'b1;
        adc_pkg::refmux_slow_pos:
          run.rd_cnt <= run.rd_cnt + 1'b1;
        // both refs off, nothing to count
        default:
          ;
      endcase

      if (sigmux)
        run.sig_cnt <= run.sig_cnt + 1'b1;

      // latch on the edge that ends rundown, held until the next one
      if (capture)
        result <= run;

      // new measurement starts from zero
      if (start)
        run <= '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/adc_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_top (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire adc_pkg::apb_req_t      apb_req,
  output wire adc_pkg::apb_data_t     prdata,
  input  wire                         comparator_val,
  output wire adc_pkg::refmux_t       refmux,
  output wire                         sigmux,
  output wire                         cmpr_latch_disable,
  output wire                         adc_valid
);

  //////////////////////////////
  // internal nets
  wire adc_pkg::adc_params_t params;
  wire adc_pkg::adc_result_t result;
  wire                       start;
  // rundown end, counters latch on it
  wire                       capture;

  // host registers and start pulse
  adc_apb_regs adc_apb_regs_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .prdata    (prdata),
    .adc_valid (adc_valid),
    .result    (result),
    .params    (params),
    .start     (start)
  );

  // phase sequencing and switch control
  adc_modulator adc_modulator_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .params             (params),
    .start              (start),
    .comparator_val     (comparator_val),
    .refmux             (refmux),
    .sigmux             (sigmux),
    .cmpr_latch_disable (cmpr_latch_disable),
    .capture            (capture),
    .adc_valid          (adc_valid)
  );

  // clock counts per reference
  adc_ref_counters adc_ref_counters_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .refmux  (refmux),
    .sigmux  (sigmux),
    .capture (capture),
    .result  (result)
  );

endmodule

`default_nettype wire
